// ==== flist.f ====
source/issue_pkg.sv
source/instr_decode.sv
source/operand_resolve.sv
source/issue_control.sv
source/issue_top.sv
testbench/issue_chk.sv
testbench/issue_tb.sv

// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - source/issue_pkg.sv
  - source/instr_decode.sv
  - source/operand_resolve.sv
  - source/issue_control.sv
  - source/issue_top.sv
  - target: test
    files:
      - testbench/issue_chk.sv
      - testbench/issue_tb.sv

// ==== testbench/issue_tb.sv ====
module issue_tb
	import issue_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_XFER = 400;
	localparam int TIMEOUT_CYCLES = N_XFER * 20;

	logic clk;
	logic reset;
	logic [WORD_W-1:0] instr;
	logic [WORD_W-1:0] curr_pc;
	logic instr_valid;
	logic predict_taken;
	logic instr_ready;
	cdb_t cdb;
	logic [NUM_ALU_RS-1:0] rs_busy;
	logic lsq_full;
	logic rob_full;
	logic [TAG_W-1:0] rob_addr;
	logic [TAG_W-1:0] rob_rd_addr1;
	logic [TAG_W-1:0] rob_rd_addr2;
	rob_read_t rob_rd1;
	rob_read_t rob_rd2;
	logic [REG_W-1:0] sr1_idx;
	logic [REG_W-1:0] sr2_idx;
	logic [REG_W-1:0] dest_idx;
	reg_status_t sr1_status;
	reg_status_t sr2_status;
	reg_status_t dest_status;
	alu_issue_t alu_issue;
	lsq_issue_t lsq_issue;
	rob_issue_t rob_issue;
	reg_claim_t reg_claim;
	redirect_t redirect;

	reg_status_t reg_tbl [8]; // Register status seen by the issue stage
	integer seed = 32'h454f3ce9;
	logic shadow_m; // Model of the wrong-path marker
	logic held; // Last cycle stalled, so the instruction stays
	int xfer_count = 0;
	int stall_count = 0;
	int discard_count = 0;
	int cycle_count = 0;

	issue_top i_dut (.*);

	assign sr1_status = reg_tbl[sr1_idx];
	assign sr2_status = reg_tbl[sr2_idx];
	assign dest_status = reg_tbl[dest_idx];

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic compare_operand(input string name, input logic got_ready,
		input logic [WORD_W-1:0] got_value, input logic [TAG_W-1:0] got_tag, input operand_t exp);
		compare({name, ".ready"}, got_ready, exp.ready);
		if (exp.ready)
			compare({name, ".value"}, got_value, exp.value);
		else
			compare({name, ".tag"}, got_tag, exp.tag); // Waiting on this producer
	endtask

	// Register first, then CDB forward, then finished ROB entry
	function automatic operand_t resolve_operand(input reg_status_t st, input rob_read_t rd);
		operand_t o;
		o.tag = st.rob_entry;
		o.ready = !st.busy || (cdb.valid && cdb.tag == st.rob_entry) || rd.valid;
		if (!st.busy)
			o.value = st.data;
		else if (cdb.valid && cdb.tag == st.rob_entry)
			o.value = cdb.data;
		else
			o.value = rd.value;
		return o;
	endfunction

	function automatic logic [WORD_W-1:0] random_instr();
		opcode_t op;
		logic [11:0] fields;
		case ($unsigned($random(seed)) % 7)
			0: op = op_add;
			1: op = op_and;
			2: op = op_not;
			3: op = op_ldr;
			4: op = op_str;
			5: op = op_br;
			default: op = op_lea;
		endcase
		fields = $random(seed);
		return {op, fields};
	endfunction

	task automatic drive_inputs();
		if (!held)
		begin
			instr_valid <= ($random(seed) & 3) != 0;
			instr <= random_instr();
			curr_pc <= $random(seed);
			predict_taken <= $random(seed);
		end
		rob_full <= ($random(seed) & 7) == 0;
		rs_busy <= $random(seed);
		lsq_full <= ($random(seed) & 3) == 0;
		rob_addr <= $random(seed);
		cdb <= $random(seed);
		rob_rd1 <= $random(seed);
		rob_rd2 <= $random(seed);
		for (int i = 0; i < 8; i++)
			reg_tbl[i] <= $random(seed);
	endtask

	task automatic check_cycle();
		logic [3:0] op;
		logic is_alu, is_ldr, is_str, is_br, is_lea, is_mem;
		logic exp_ready, xfer, keep;
		reg_status_t st1, st2, std;
		operand_t o1, o2, os, ok;
		logic [WORD_W-1:0] sext5, adj6, adj9, target;
		logic [1:0] station;
		op = instr[15:12];
		is_alu = (op == op_add) || (op == op_and) || (op == op_not);
		is_ldr = op == op_ldr;
		is_str = op == op_str;
		is_br = op == op_br;
		is_lea = op == op_lea;
		is_mem = is_ldr || is_str;
		exp_ready = !(instr_valid && (rob_full || (is_alu && rs_busy == 3'b111)
			|| (is_mem && lsq_full)));
		xfer = instr_valid && exp_ready;
		keep = xfer && !shadow_m && !reset;
		compare("instr_ready", instr_ready, exp_ready);
		compare("sr1_idx", sr1_idx, instr[8:6]);
		compare("sr2_idx", sr2_idx, instr[2:0]);
		compare("dest_idx", dest_idx, instr[11:9]);
		st1 = reg_tbl[instr[8:6]];
		st2 = reg_tbl[instr[2:0]];
		std = reg_tbl[instr[11:9]];
		compare("rob_rd_addr1", rob_rd_addr1, st1.rob_entry);
		compare("rob_rd_addr2", rob_rd_addr2, is_str ? std.rob_entry : st2.rob_entry);
		o1 = resolve_operand(st1, rob_rd1);
		o2 = resolve_operand(st2, rob_rd2);
		os = resolve_operand(std, rob_rd2);
		sext5 = 16'($signed(instr[4:0]));
		adj6 = 16'($signed(instr[5:0])) << 1;
		adj9 = 16'($signed(instr[8:0])) << 1;
		target = curr_pc + adj9;
		if (!rs_busy[0])
			station = 2'd0;
		else if (!rs_busy[1])
			station = 2'd1;
		else
			station = 2'd2;
		compare("alu_issue.valid", alu_issue.valid, keep && is_alu);
		compare("lsq_issue.valid", lsq_issue.valid, keep && is_mem);
		compare("rob_issue.valid", rob_issue.valid, keep && (is_alu || is_mem || is_br || is_lea));
		compare("reg_claim.valid", reg_claim.valid, keep && (is_alu || is_ldr || is_lea));
		compare("redirect.valid", redirect.valid, keep && is_br && predict_taken);
		if (keep && is_alu)
		begin
			compare("alu_issue.station", alu_issue.station, station);
			compare("alu_issue.opcode", alu_issue.opcode, op);
			compare_operand("alu_issue.j", alu_issue.j_ready, alu_issue.vj, alu_issue.qj, o1);
			if (instr[5])
			begin
				ok.ready = 1'b1;
				ok.value = sext5;
				ok.tag = '0;
			end
			else
				ok = o2;
			compare_operand("alu_issue.k", alu_issue.k_ready, alu_issue.vk, alu_issue.qk, ok);
			compare("alu_issue.dest_tag", alu_issue.dest_tag, rob_addr);
		end
		if (keep && is_mem)
		begin
			compare("lsq_issue.is_store", lsq_issue.is_store, is_str);
			compare_operand("lsq_issue.base", lsq_issue.base.ready, lsq_issue.base.value,
				lsq_issue.base.tag, o1);
			compare("lsq_issue.offset", lsq_issue.offset, adj6);
			if (is_str)
				compare_operand("lsq_issue.src", lsq_issue.src.ready, lsq_issue.src.value,
					lsq_issue.src.tag, os);
			else
				compare("lsq_issue.dest_tag", lsq_issue.dest_tag, rob_addr);
		end
		if (rob_issue.valid)
		begin
			compare("rob_issue.opcode", rob_issue.opcode, op);
			compare("rob_issue.dest", rob_issue.dest, is_str ? 3'd0 : instr[11:9]);
			if (is_br)
				compare("rob_issue.value", rob_issue.value, predict_taken ? curr_pc : target);
			if (is_lea)
				compare("rob_issue.value", rob_issue.value, target);
		end
		if (reg_claim.valid)
		begin
			compare("reg_claim.idx", reg_claim.idx, instr[11:9]);
			compare("reg_claim.tag", reg_claim.tag, rob_addr);
		end
		if (redirect.valid)
			compare("redirect.target", redirect.target, target);
		if (instr_valid && !exp_ready)
			stall_count++;
		if (xfer && shadow_m)
			discard_count++;
		if (xfer)
			xfer_count++;
		held = instr_valid && !exp_ready;
		if (reset)
			shadow_m = 1'b0;
		else if (xfer)
			shadow_m = keep && is_br && predict_taken; // Sets only on a kept taken branch
	endtask

	always @(negedge clk)
		check_cycle();

	// A failed assertion in the bound checker ends the run
	always @(negedge clk)
	begin
		if (i_dut.i_chk.fail_count != 0)
		begin
			$display("A concurrent assertion in the bound checker failed");
			$display("RESULT: FAIL");
			$fatal(1, "Assertion failure");
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("Timeout: the transfers did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		reset = 1'b1;
		instr = '0;
		curr_pc = '0;
		instr_valid = 1'b0;
		predict_taken = 1'b0;
		cdb = '0;
		rs_busy = '0;
		lsq_full = 1'b0;
		rob_full = 1'b0;
		rob_addr = '0;
		rob_rd1 = '0;
		rob_rd2 = '0;
		shadow_m = 1'b0;
		held = 1'b0;
		for (int i = 0; i < 8; i++)
			reg_tbl[i] = $random(seed);
		repeat (4)
		begin
			@(posedge clk);
			drive_inputs(); // Instructions arrive in reset too
		end
		reset <= 1'b0;
		while (xfer_count < N_XFER)
		begin
			@(posedge clk);
			drive_inputs();
		end
		if (stall_count == 0 || discard_count == 0)
		begin
			$display("The stimulus never produced a stall or a branch shadow discard");
			$display("RESULT: FAIL");
			$fatal(1, "Incomplete stimulus");
		end
		else
		begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== testbench/issue_chk.sv ====
module issue_chk
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [WORD_W-1:0] instr,
	input logic instr_valid,
	input logic rob_full,
	input logic lsq_full,
	input logic [NUM_ALU_RS-1:0] rs_busy,
	input alu_issue_t alu_issue,
	input lsq_issue_t lsq_issue,
	input rob_issue_t rob_issue,
	input reg_claim_t reg_claim,
	input redirect_t redirect
);

	timeunit 1ns;
	timeprecision 1ps;

	logic any_valid;
	int fail_count = 0; // Failed assertions so far

	assign any_valid = alu_issue.valid || lsq_issue.valid || rob_issue.valid
		|| reg_claim.valid || redirect.valid;

	// Dispatch needs a valid instruction and no back-pressure
	assert property (@(posedge clk) disable iff (reset)
		any_valid |-> (instr_valid && !rob_full
			&& !(alu_issue.valid && (&rs_busy))
			&& !(lsq_issue.valid && lsq_full)))
	else
	begin
		$error("Dispatch valid without an instruction transfer");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset)
		!(alu_issue.valid && lsq_issue.valid))
	else
	begin
		$error("ALU and load/store dispatch in the same cycle");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset)
		redirect.valid |-> (instr[15:12] == op_br))
	else
	begin
		$error("Fetch redirect from an instruction that is not a branch");
		fail_count++;
	end

	assert property (@(posedge clk)
		reset |-> !any_valid)
	else
	begin
		$error("Dispatch valid while in reset");
		fail_count++;
	end

endmodule

bind issue_top issue_chk i_chk (
	.clk(clk),
	.reset(reset),
	.instr(instr),
	.instr_valid(instr_valid),
	.rob_full(rob_full),
	.lsq_full(lsq_full),
	.rs_busy(rs_busy),
	.alu_issue(alu_issue),
	.lsq_issue(lsq_issue),
	.rob_issue(rob_issue),
	.reg_claim(reg_claim),
	.redirect(redirect)
);

// ==== source/issue_top.sv ====
module issue_top
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [WORD_W-1:0] instr,
	input logic [WORD_W-1:0] curr_pc,
	input logic instr_valid,
	input logic predict_taken,
	output logic instr_ready,
	input cdb_t cdb,
	input logic [NUM_ALU_RS-1:0] rs_busy,
	input logic lsq_full,
	input logic rob_full,
	input logic [TAG_W-1:0] rob_addr,
	output logic [TAG_W-1:0] rob_rd_addr1,
	output logic [TAG_W-1:0] rob_rd_addr2,
	input rob_read_t rob_rd1,
	input rob_read_t rob_rd2,
	output logic [REG_W-1:0] sr1_idx,
	output logic [REG_W-1:0] sr2_idx,
	output logic [REG_W-1:0] dest_idx,
	input reg_status_t sr1_status,
	input reg_status_t sr2_status,
	input reg_status_t dest_status,
	output alu_issue_t alu_issue,
	output lsq_issue_t lsq_issue,
	output rob_issue_t rob_issue,
	output reg_claim_t reg_claim,
	output redirect_t redirect
);

	decoded_t dec;
	operand_t sr1_opnd;
	operand_t sr2_opnd;
	operand_t src_opnd;

	// Register file lookups straight from decode
	assign sr1_idx = dec.sr1;
	assign sr2_idx = dec.sr2;
	assign dest_idx = dec.dest;

	instr_decode i_decode (
		.instr(instr),
		.dec(dec)
	);

	operand_resolve i_sr1_resolve (
		.status(sr1_status),
		.cdb(cdb),
		.rob_read(rob_rd1),
		.opnd(sr1_opnd)
	);

	operand_resolve i_sr2_resolve (
		.status(sr2_status),
		.cdb(cdb),
		.rob_read(rob_rd2),
		.opnd(sr2_opnd)
	);

	// Store source shares ROB port 2 with sr2
	operand_resolve i_src_resolve (
		.status(dest_status),
		.cdb(cdb),
		.rob_read(rob_rd2),
		.opnd(src_opnd)
	);

	issue_control i_control (
		.clk(clk),
		.reset(reset),
		.dec(dec),
		.instr_valid(instr_valid),
		.curr_pc(curr_pc),
		.predict_taken(predict_taken),
		.rob_full(rob_full),
		.lsq_full(lsq_full),
		.rs_busy(rs_busy),
		.rob_addr(rob_addr),
		.sr1_opnd(sr1_opnd),
		.sr2_opnd(sr2_opnd),
		.src_opnd(src_opnd),
		.sr1_status(sr1_status),
		.sr2_status(sr2_status),
		.dest_status(dest_status),
		.instr_ready(instr_ready),
		.rob_rd_addr1(rob_rd_addr1),
		.rob_rd_addr2(rob_rd_addr2),
		.alu_issue(alu_issue),
		.lsq_issue(lsq_issue),
		.rob_issue(rob_issue),
		.reg_claim(reg_claim),
		.redirect(redirect)
	);

endmodule

// ==== source/issue_control.sv ====
module issue_control
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input decoded_t dec,
	input logic instr_valid,
	input logic [WORD_W-1:0] curr_pc,
	input logic predict_taken,
	input logic rob_full,
	input logic lsq_full,
	input logic [NUM_ALU_RS-1:0] rs_busy,
	input logic [TAG_W-1:0] rob_addr,
	input operand_t sr1_opnd,
	input operand_t sr2_opnd,
	input operand_t src_opnd,
	input reg_status_t sr1_status,
	input reg_status_t sr2_status,
	input reg_status_t dest_status,
	output logic instr_ready,
	output logic [TAG_W-1:0] rob_rd_addr1,
	output logic [TAG_W-1:0] rob_rd_addr2,
	output alu_issue_t alu_issue,
	output lsq_issue_t lsq_issue,
	output rob_issue_t rob_issue,
	output reg_claim_t reg_claim,
	output redirect_t redirect
);

	logic is_mem;
	logic stall;
	logic xfer;
	logic keep;
	logic shadow; // Next transfer is on the wrong path
	logic [STATION_W-1:0] station;
	logic [WORD_W-1:0] br_target;

	assign is_mem = dec.is_load || dec.is_store;

	assign stall = instr_valid && (rob_full
		|| (dec.is_alu && (&rs_busy))
		|| (is_mem && lsq_full));
	assign instr_ready = !stall;

	assign xfer = instr_valid && instr_ready;
	assign keep = xfer && !shadow && !reset; // Nothing dispatches in reset

	// Store data sits in the dest field, so port 2 follows it for STR
	assign rob_rd_addr1 = sr1_status.rob_entry;
	assign rob_rd_addr2 = dec.is_store ? dest_status.rob_entry : sr2_status.rob_entry;

	always_ff @(posedge clk)
	begin
		if (reset)
			shadow <= 1'b0;
		else if (xfer)
			shadow <= keep && dec.is_branch && predict_taken;
	end

	// Lowest free station wins
	always_comb
	begin
		station = '0;
		for (int i = NUM_ALU_RS - 1; i >= 0; i--)
		begin
			if (!rs_busy[i])
				station = STATION_W'(i);
		end
	end

	assign br_target = curr_pc + dec.adj9;

	always_comb
	begin
		alu_issue.valid = keep && dec.is_alu;
		alu_issue.station = station;
		alu_issue.opcode = dec.opcode;
		alu_issue.vj = sr1_opnd.value;
		alu_issue.qj = sr1_opnd.tag;
		alu_issue.j_ready = sr1_opnd.ready;
		if (dec.imm)
		begin
			alu_issue.vk = dec.sext5;
			alu_issue.qk = '0;
			alu_issue.k_ready = 1'b1;
		end
		else
		begin
			alu_issue.vk = sr2_opnd.value;
			alu_issue.qk = sr2_opnd.tag;
			alu_issue.k_ready = sr2_opnd.ready;
		end
		alu_issue.dest_tag = rob_addr;
	end

	always_comb
	begin
		lsq_issue.valid = keep && is_mem;
		lsq_issue.is_store = dec.is_store;
		lsq_issue.base = sr1_opnd;
		lsq_issue.src = src_opnd; // Only meaningful for STR
		lsq_issue.offset = dec.adj6;
		lsq_issue.dest_tag = rob_addr;
	end

	always_comb
	begin
		rob_issue.valid = keep && (dec.is_alu || is_mem || dec.is_branch || dec.is_lea);
		rob_issue.opcode = dec.opcode;
		rob_issue.dest = dec.is_store ? '0 : dec.dest;
		if (dec.is_branch)
			rob_issue.value = predict_taken ? curr_pc : br_target; // Keep the other path
		else if (dec.is_lea)
			rob_issue.value = br_target;
		else
			rob_issue.value = '0;
	end

	always_comb
	begin
		reg_claim.valid = keep && (dec.is_alu || dec.is_load || dec.is_lea);
		reg_claim.idx = dec.dest;
		reg_claim.tag = rob_addr;

		redirect.valid = keep && dec.is_branch && predict_taken;
		redirect.target = br_target;
	end

endmodule

// ==== source/operand_resolve.sv ====
module operand_resolve
	import issue_pkg::*;
(
	input reg_status_t status,
	input cdb_t cdb,
	input rob_read_t rob_read,
	output operand_t opnd
);

	logic cdb_hit;

	// Broadcast carries the tag this register waits on
	assign cdb_hit = cdb.valid && (cdb.tag == status.rob_entry);

	always_comb
	begin
		opnd.tag = status.rob_entry;
		if (!status.busy)
		begin
			opnd.ready = 1'b1;
			opnd.value = status.data;
		end
		else if (cdb_hit)
		begin
			opnd.ready = 1'b1;
			opnd.value = cdb.data;
		end
		else if (rob_read.valid)
		begin
			opnd.ready = 1'b1; // Finished but not yet committed
			opnd.value = rob_read.value;
		end
		else
		begin
			opnd.ready = 1'b0;
			opnd.value = '0;
		end
	end

endmodule

// ==== source/instr_decode.sv ====
module instr_decode
	import issue_pkg::*;
(
	input logic [WORD_W-1:0] instr,
	output decoded_t dec
);

	opcode_t op;

	assign op = opcode_t'(instr[15:12]);

	always_comb
	begin
		dec.opcode = op;
		dec.dest = instr[11:9];
		dec.sr1 = instr[8:6];
		dec.sr2 = instr[2:0];
		dec.imm = instr[5];

		// Immediates, the two offsets are word aligned
		dec.sext5 = {{(WORD_W-5){instr[4]}}, instr[4:0]};
		dec.adj6 = {{(WORD_W-7){instr[5]}}, instr[5:0], 1'b0};
		dec.adj9 = {{(WORD_W-10){instr[8]}}, instr[8:0], 1'b0};

		dec.is_alu = 1'b0;
		dec.is_load = 1'b0;
		dec.is_store = 1'b0;
		dec.is_branch = 1'b0;
		dec.is_lea = 1'b0;

		case (op)
			op_add, op_and, op_not:
			begin
				dec.is_alu = 1'b1;
			end
			op_ldr:
			begin
				dec.is_load = 1'b1;
			end
			op_str:
			begin
				dec.is_store = 1'b1;
			end
			op_br:
			begin
				dec.is_branch = 1'b1;
			end
			op_lea:
			begin
				dec.is_lea = 1'b1;
			end
			default: ; // Unsupported opcodes get no class and are dropped at issue
		endcase
	end

endmodule

// ==== source/issue_pkg.sv ====
package issue_pkg;

	localparam int WORD_W = 16;
	localparam int TAG_W = 3;
	localparam int REG_W = 3;
	localparam int NUM_ALU_RS = 3;
	localparam int STATION_W = 2; // Enough ids for NUM_ALU_RS stations

	// LC-3b opcode field, bits 15..12
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} opcode_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [WORD_W-1:0] data;
	} cdb_t;

	typedef struct packed {
		logic busy;
		logic [TAG_W-1:0] rob_entry; // Producer of the pending value
		logic [WORD_W-1:0] data;
	} reg_status_t;

	typedef struct packed {
		logic valid;
		logic [WORD_W-1:0] value;
	} rob_read_t;

	typedef struct packed {
		logic ready;
		logic [WORD_W-1:0] value;
		logic [TAG_W-1:0] tag;
	} operand_t;

	typedef struct packed {
		opcode_t opcode;
		logic [REG_W-1:0] dest;
		logic [REG_W-1:0] sr1;
		logic [REG_W-1:0] sr2;
		logic imm; // Bit 5 of the word
		logic [WORD_W-1:0] sext5;
		logic [WORD_W-1:0] adj6;
		logic [WORD_W-1:0] adj9;
		logic is_alu;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_lea;
	} decoded_t;

	typedef struct packed {
		logic valid;
		logic [STATION_W-1:0] station;
		opcode_t opcode;
		logic [WORD_W-1:0] vj;
		logic [TAG_W-1:0] qj;
		logic j_ready;
		logic [WORD_W-1:0] vk;
		logic [TAG_W-1:0] qk;
		logic k_ready;
		logic [TAG_W-1:0] dest_tag;
	} alu_issue_t;

	typedef struct packed {
		logic valid;
		logic is_store;
		operand_t base;
		operand_t src;
		logic [WORD_W-1:0] offset;
		logic [TAG_W-1:0] dest_tag;
	} lsq_issue_t;

	typedef struct packed {
		logic valid;
		opcode_t opcode;
		logic [REG_W-1:0] dest;
		logic [WORD_W-1:0] value;
	} rob_issue_t;

	typedef struct packed {
		logic valid;
		logic [REG_W-1:0] idx;
		logic [TAG_W-1:0] tag;
	} reg_claim_t;

	typedef struct packed {
		logic valid;
		logic [WORD_W-1:0] target;
	} redirect_t;

endpackage
